// ==== sim.f ====
+incdir+include
logic/lsu_pkg.sv
logic/lsu_agu.sv
logic/lsu_store_queue.sv
logic/lsu_load_unit.sv
logic/lsu_top.sv
tests/lsu_tb.sv

// ==== Bender.yml ====
package:
  name: lsu

sources:
  - include_dirs:
      - include
    files:
      - logic/lsu_pkg.sv
      - logic/lsu_agu.sv
      - logic/lsu_store_queue.sv
      - logic/lsu_load_unit.sv
      - logic/lsu_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - tests/lsu_tb.sv

// ==== tests/lsu_tb.sv ====
// Random-stimulus testbench for lsu_top with memory and store queue models, run as top module lsu_tb
`timescale 1ns/100ps
`default_nettype none

`include "lsu_macros.svh"

module lsu_tb;

  localparam int len_forward  = 40;
  localparam int len_merge    = 50;
  localparam int len_extend   = 60;
  localparam int len_misalign = 40;
  localparam int len_commit   = 60;
  localparam int len_flush    = 40;
  localparam int timeout_cycles =
    (len_forward + len_merge + len_extend + len_misalign + len_commit + len_flush) * 12;
  localparam logic [`LSU_PLEN-1:0] pool_base = 32'h1234_5000;

  logic                 clk_i;
  logic                 rst_ni;
  logic                 flush_i;
  logic                 req_valid_i;
  logic                 req_ready_o;
  lsu_pkg::lsu_req_t    req_i;
  logic                 mem_req_valid_o;
  logic                 mem_req_ready_i;
  logic [`LSU_PLEN-1:0] mem_req_addr_o;
  logic                 mem_rsp_valid_i;
  logic [`LSU_XLEN-1:0] mem_rsp_data_i;
  logic                 wb_valid_o;
  lsu_pkg::lsu_wb_t     wb_o;
  logic                 commit_i;
  logic                 st_valid_o;
  lsu_pkg::st_write_t   st_o;

  integer               seed;
  int                   cycle_cnt = 0;
  int                   checks;
  int                   errors;
  int                   test_checks;
  int                   test_errors;
  logic [`LSU_XLEN-1:0] mem_model [logic [`LSU_PLEN-1:0]];
  lsu_pkg::sq_entry_t   sq_model [$];
  logic                 accepted;
  logic                 got_wb;
  logic                 got_st;
  lsu_pkg::lsu_wb_t     wb_cap;
  lsu_pkg::st_write_t   st_cap;
  int                   wb_count;
  int                   reads_seen;
  logic [`LSU_PLEN-1:0] read_addr;
  logic                 rsp_pending;
  int                   rsp_delay;

  lsu_top u_dut (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .flush_i         (flush_i),
    .req_valid_i     (req_valid_i),
    .req_ready_o     (req_ready_o),
    .req_i           (req_i),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_req_ready_i (mem_req_ready_i),
    .mem_req_addr_o  (mem_req_addr_o),
    .mem_rsp_valid_i (mem_rsp_valid_i),
    .mem_rsp_data_i  (mem_rsp_data_i),
    .wb_valid_o      (wb_valid_o),
    .wb_o            (wb_o),
    .commit_i        (commit_i),
    .st_valid_o      (st_valid_o),
    .st_o            (st_o)
  );

  always #2 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  initial begin : watchdog
    while (cycle_cnt < timeout_cycles) begin
      @(posedge clk_i);
    end
    $display("timeout: run did not finish within %0d cycles", timeout_cycles);
    $display("CHECKS FAILED");
    $finish;
  end

  // ========================================
  // Reference helpers
  // ========================================

  function automatic int pick(input int n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic int size_bytes(input lsu_pkg::lsu_op_e op);
    int n;
    case (op)
      lsu_pkg::LSU_LB, lsu_pkg::LSU_LBU, lsu_pkg::LSU_SB: n = 1;
      lsu_pkg::LSU_LH, lsu_pkg::LSU_LHU, lsu_pkg::LSU_SH: n = 2;
      lsu_pkg::LSU_LW, lsu_pkg::LSU_LWU, lsu_pkg::LSU_SW: n = 4;
      default:                                            n = 8;
    endcase
    return n;
  endfunction

  function automatic logic [`LSU_XLEN-1:0] low_bytes(input int n);
    return (n >= 8) ? {`LSU_XLEN{1'b1}} : ((64'd1 << (8 * n)) - 64'd1);
  endfunction

  // Unwritten words read back a pattern built from the full address
  function automatic logic [`LSU_XLEN-1:0] memory_word(input logic [`LSU_PLEN-1:0] addr);
    logic [`LSU_XLEN-1:0] word;
    word = {addr ^ 32'h9e37_79b9, ~addr + 32'h0101_0101};
    if (mem_model.exists(addr)) begin
      word = mem_model[addr];
    end
    return word;
  endfunction

  function automatic logic [`LSU_XLEN-1:0] extend_load(input lsu_pkg::lsu_op_e op,
                                                      input logic [`LSU_XLEN-1:0] raw);
    logic [`LSU_XLEN-1:0] keep;
    logic [`LSU_XLEN-1:0] val;
    int                   n;
    n    = size_bytes(op);
    keep = low_bytes(n);
    val  = raw & keep;
    if ((op == lsu_pkg::LSU_LB || op == lsu_pkg::LSU_LH || op == lsu_pkg::LSU_LW) &&
        val[8*n-1]) begin
      val = val | ~keep;
    end
    return val;
  endfunction

  // ========================================
  // Cycle step with memory responder
  // ========================================

  // Samples at the falling edge, drives 1 ns after the rising edge
  task automatic cycle();
    @(negedge clk_i);
    if (req_valid_i && req_ready_o) begin
      accepted = 1'b1;
    end
    if (wb_valid_o) begin
      got_wb = 1'b1;
      wb_cap = wb_o;
      wb_count++;
    end
    if (st_valid_o) begin
      got_st = 1'b1;
      st_cap = st_o;
    end
    if (mem_req_valid_o && mem_req_ready_i) begin
      reads_seen++;
      read_addr   = mem_req_addr_o;
      rsp_pending = 1'b1;
      rsp_delay   = 1 + pick(5);
    end
    @(posedge clk_i);
    #1;
    mem_rsp_valid_i = 1'b0;
    mem_req_ready_i = pick(4) != 0;
    if (rsp_pending) begin
      rsp_delay--;
      if (rsp_delay == 0) begin
        mem_rsp_valid_i = 1'b1;
        mem_rsp_data_i  = memory_word(read_addr);
        rsp_pending     = 1'b0;
      end
    end
  endtask

  task automatic send_request(input lsu_pkg::lsu_op_e op, input logic [`LSU_PLEN-1:0] addr,
                              input logic [`LSU_XLEN-1:0] rs2, input logic [`LSU_ROB_W-1:0] rob);
    logic [31:0]          r;
    logic [31:0]          upper;
    logic [`LSU_XLEN-1:0] imm;
    r             = $random(seed);
    upper         = $random(seed);
    imm           = {{52{r[11]}}, r[11:0]};
    req_i.op      = op;
    req_i.imm     = imm;
    req_i.rs1     = {upper, addr} - imm;
    req_i.rs2     = rs2;
    req_i.rob_tag = rob;
    reads_seen    = 0;
    got_wb        = 1'b0;
    accepted      = 1'b0;
    req_valid_i   = 1'b1;
    while (!accepted) begin
      cycle();
    end
    req_valid_i = 1'b0;
  endtask

  // ========================================
  // Operations
  // ========================================

  task automatic commit_store(input string name);
    lsu_pkg::sq_entry_t   ent;
    lsu_pkg::st_write_t   exp_st;
    logic [`LSU_XLEN-1:0] cur;
    logic                 was_empty;
    was_empty = sq_model.size() == 0;
    got_st    = 1'b0;
    commit_i  = 1'b1;
    cycle();
    commit_i = 1'b0;
    cycle();
    test_checks++;
    if (was_empty) begin
      if (got_st) begin
        test_errors++;
        $display("%s: store write appeared for a commit to an empty store queue", name);
      end
    end else begin
      ent              = sq_model.pop_front();
      exp_st.word_addr = ent.word_addr;
      exp_st.data      = ent.data;
      exp_st.be        = ent.be;
      if (!got_st) begin
        test_errors++;
        $display("%s: no store write followed a commit", name);
      end else if (st_cap !== exp_st) begin
        test_errors++;
        $display("** Error %s: store write expected %h actual %h", name, exp_st, st_cap);
      end
      cur = memory_word(ent.word_addr);
      for (int b = 0; b < `LSU_BE_W; b++) begin
        if (ent.be[b]) begin
          cur[8*b +: 8] = ent.data[8*b +: 8];
        end
      end
      mem_model[ent.word_addr] = cur;
    end
  endtask

  task automatic access(input string name, input logic store, input logic mis,
                        input int n_words);
    lsu_pkg::lsu_op_e     op;
    lsu_pkg::sq_entry_t   ent;
    lsu_pkg::lsu_wb_t     exp_wb;
    logic [`LSU_PLEN-1:0] word;
    logic [`LSU_XLEN-1:0] rs2;
    logic [`LSU_XLEN-1:0] merged;
    logic [`LSU_BE_W-1:0] be;
    logic [`LSU_BE_W-1:0] hit;
    int                   n;
    int                   off;
    int                   exp_reads;
    if (store && sq_model.size() == `LSU_SQ_DEPTH) begin
      commit_store(name);
    end
    op = store ? lsu_pkg::lsu_op_e'(4'(7 + pick(4))) : lsu_pkg::lsu_op_e'(4'(pick(7)));
    n  = size_bytes(op);
    if (mis && n > 1) begin
      off = 9 - n + pick(n - 1);
    end else begin
      off = pick(9 - n);
    end
    word           = pool_base + 32'(pick(n_words) * 8);
    rs2            = {$random(seed), $random(seed)};
    be             = 8'(((1 << n) - 1) << off);
    exp_wb         = '0;
    exp_wb.rob_tag = `LSU_ROB_W'(pick(64));
    exp_reads      = 0;
    if (off + n > `LSU_BE_W) begin
      exp_wb.exception = 1'b1;
      exp_wb.cause     = store ? `LSU_ECAUSE_W'(`LSU_ECAUSE_ST_MISALIGN)
                               : `LSU_ECAUSE_W'(`LSU_ECAUSE_LD_MISALIGN);
    end else if (store) begin
      ent.word_addr = word;
      ent.be        = be;
      ent.data      = (rs2 & low_bytes(n)) << (8 * off);
      sq_model.push_back(ent);
    end else begin
      // Later stores to the word win each byte
      merged = memory_word(word);
      hit    = '0;
      foreach (sq_model[i]) begin
        if (sq_model[i].word_addr == word) begin
          for (int b = 0; b < `LSU_BE_W; b++) begin
            if (sq_model[i].be[b]) begin
              merged[8*b +: 8] = sq_model[i].data[8*b +: 8];
              hit[b]           = 1'b1;
            end
          end
        end
      end
      exp_wb.data = extend_load(op, merged >> (8 * off));
      exp_reads   = ((hit & be) == be) ? 0 : 1;
    end
    send_request(op, word + 32'(off), rs2, exp_wb.rob_tag);
    while (!got_wb) begin
      cycle();
    end
    test_checks++;
    if (wb_cap !== exp_wb) begin
      test_errors++;
      $display("** Error %s: writeback expected %h actual %h", name, exp_wb, wb_cap);
    end
    test_checks++;
    if (reads_seen != exp_reads) begin
      test_errors++;
      $display("** Error %s: memory reads expected %0d actual %0d", name, exp_reads, reads_seen);
    end else if (exp_reads == 1 && read_addr !== word) begin
      test_errors++;
      $display("** Error %s: read address expected %h actual %h", name, word, read_addr);
    end
  endtask

  // Load to a word outside the store pool, so it always misses
  task automatic flush_load(input string name);
    lsu_pkg::lsu_op_e op;
    int               n;
    int               k;
    int               wb_before;
    op        = lsu_pkg::lsu_op_e'(4'(pick(7)));
    n         = size_bytes(op);
    k         = pick(3);
    wb_before = wb_count;
    send_request(op, pool_base + 32'h100 + 32'(pick(16) * 8) + 32'(pick(9 - n)),
                 {$random(seed), $random(seed)}, `LSU_ROB_W'(pick(64)));
    repeat (k) begin
      cycle();
    end
    flush_i = 1'b1;
    cycle();
    flush_i = 1'b0;
    sq_model.delete();
    while (rsp_pending) begin
      cycle();
    end
    repeat (2) begin
      cycle();
    end
    test_checks++;
    if (wb_count != wb_before) begin
      test_errors++;
      $display("%s: a flushed load still wrote back", name);
    end
    commit_store(name);
  endtask

  task automatic run_test(input string name, input int n_ops, input int st_pct,
                          input int mis_pct, input int cm_pct, input int fl_pct,
                          input int n_words);
    int r;
    test_checks = 0;
    test_errors = 0;
    for (int i = 0; i < n_ops; i++) begin
      r = pick(100);
      if (r < cm_pct) begin
        commit_store(name);
      end else if (r < cm_pct + fl_pct) begin
        flush_load(name);
      end else begin
        access(name, pick(100) < st_pct, pick(100) < mis_pct, n_words);
      end
    end
    checks += test_checks;
    errors += test_errors;
    $display("test %-14s %4d checks  %0d errors", name, test_checks, test_errors);
  endtask

  // ========================================
  // Main sequence
  // ========================================

  initial begin : main
    seed            = 83325;
    checks          = 0;
    errors          = 0;
    clk_i           = 1'b0;
    rst_ni          = 1'b0;
    flush_i         = 1'b0;
    req_valid_i     = 1'b0;
    req_i           = '0;
    mem_req_ready_i = 1'b0;
    mem_rsp_valid_i = 1'b0;
    mem_rsp_data_i  = '0;
    commit_i        = 1'b0;
    accepted        = 1'b0;
    got_wb          = 1'b0;
    got_st          = 1'b0;
    wb_count        = 0;
    reads_seen      = 0;
    read_addr       = '0;
    rsp_pending     = 1'b0;
    rsp_delay       = 0;
    repeat (2) begin
      @(posedge clk_i);
    end
    #1;
    rst_ni = 1'b1;
    @(negedge clk_i);
    checks++;
    if (!req_ready_o || wb_valid_o || st_valid_o || mem_req_valid_o) begin
      errors++;
      $display("reset: outputs are not idle after reset");
    end
    @(posedge clk_i);
    #1;
    run_test("store_forward", len_forward, 60, 0, 5, 0, 1);
    run_test("partial_merge", len_merge, 50, 0, 10, 0, 4);
    run_test("extension", len_extend, 25, 0, 15, 0, 8);
    run_test("misaligned", len_misalign, 50, 50, 10, 0, 4);
    run_test("commit_order", len_commit, 50, 0, 40, 0, 4);
    run_test("flush", len_flush, 50, 0, 15, 20, 4);
    $display("summary %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== logic/lsu_top.sv ====
// Top level of the load/store unit that connects address stage, store queue and load unit
`timescale 1ns/100ps
`default_nettype none

`include "lsu_macros.svh"

module lsu_top (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 flush_i,
  input  logic                 req_valid_i,
  output logic                 req_ready_o,
  input  lsu_pkg::lsu_req_t    req_i,
  output logic                 mem_req_valid_o,
  input  logic                 mem_req_ready_i,
  output logic [`LSU_PLEN-1:0] mem_req_addr_o,
  input  logic                 mem_rsp_valid_i,
  input  logic [`LSU_XLEN-1:0] mem_rsp_data_i,
  output logic                 wb_valid_o,
  output lsu_pkg::lsu_wb_t     wb_o,
  input  logic                 commit_i,
  output logic                 st_valid_o,
  output lsu_pkg::st_write_t   st_o
);

  logic                stage_valid;
  lsu_pkg::lsu_stage_t stage;
  lsu_pkg::fwd_t       fwd;
  logic                sq_full;
  logic                ld_busy;

  lsu_agu u_agu (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_i       (flush_i),
    .req_valid_i   (req_valid_i),
    .req_ready_o   (req_ready_o),
    .req_i         (req_i),
    .sq_full_i     (sq_full),
    .ld_busy_i     (ld_busy),
    .stage_valid_o (stage_valid),
    .stage_o       (stage)
  );

  lsu_store_queue u_store_queue (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_i       (flush_i),
    .stage_valid_i (stage_valid),
    .stage_i       (stage),
    .commit_i      (commit_i),
    .fwd_o         (fwd),
    .sq_full_o     (sq_full),
    .st_valid_o    (st_valid_o),
    .st_o          (st_o)
  );

  lsu_load_unit u_load_unit (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .flush_i         (flush_i),
    .stage_valid_i   (stage_valid),
    .stage_i         (stage),
    .fwd_i           (fwd),
    .ld_busy_o       (ld_busy),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_req_ready_i (mem_req_ready_i),
    .mem_req_addr_o  (mem_req_addr_o),
    .mem_rsp_valid_i (mem_rsp_valid_i),
    .mem_rsp_data_i  (mem_rsp_data_i),
    .wb_valid_o      (wb_valid_o),
    .wb_o            (wb_o)
  );

endmodule

`default_nettype wire

// ==== logic/lsu_load_unit.sv ====
// Output stage that reads memory for uncovered loads, merges and extends data and writes back
`timescale 1ns/100ps
`default_nettype none

`include "lsu_macros.svh"

module lsu_load_unit (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 flush_i,
  input  logic                 stage_valid_i,
  input  lsu_pkg::lsu_stage_t  stage_i,
  input  lsu_pkg::fwd_t        fwd_i,
  output logic                 ld_busy_o,
  output logic                 mem_req_valid_o,
  input  logic                 mem_req_ready_i,
  output logic [`LSU_PLEN-1:0] mem_req_addr_o,
  input  logic                 mem_rsp_valid_i,
  input  logic [`LSU_XLEN-1:0] mem_rsp_data_i,
  output logic                 wb_valid_o,
  output lsu_pkg::lsu_wb_t     wb_o
);

  typedef enum logic [2:0] {
    LD_IDLE,
    LD_REQ,
    LD_RSP,
    LD_WB,
    LD_DRAIN
  } ld_state_e;

  ld_state_e               state_q;
  ld_state_e               state_d;
  logic                    stage_go;
  logic                    stage_store;
  logic                    covered;
  logic                    miss_start;
  logic                    imm_wb;
  logic                    rsp_wb;
  logic                    wb_fire;
  lsu_pkg::lsu_wb_t        wb_d;
  logic                    wb_valid_q;
  lsu_pkg::lsu_wb_t        wb_q;
  lsu_pkg::lsu_op_e        pend_op_q;
  logic [`LSU_OFF_W-1:0]   pend_off_q;
  logic [`LSU_ROB_W-1:0]   pend_rob_q;
  logic [`LSU_PLEN-1:0]    pend_addr_q;
  lsu_pkg::fwd_t           pend_fwd_q;

  // Forwarded bytes over memory bytes, then shift and extend
  function automatic logic [`LSU_XLEN-1:0] load_value(input lsu_pkg::lsu_op_e      op,
                                                      input logic [`LSU_OFF_W-1:0] off,
                                                      input lsu_pkg::fwd_t         fwd,
                                                      input logic [`LSU_XLEN-1:0]  mem_data);
    logic [`LSU_XLEN-1:0] merged;
    logic [`LSU_XLEN-1:0] shifted;
    logic [`LSU_XLEN-1:0] result;
    for (int b = 0; b < `LSU_BE_W; b++) begin
      merged[8*b +: 8] = fwd.mask[b] ? fwd.data[8*b +: 8] : mem_data[8*b +: 8];
    end
    shifted = merged >> {off, 3'b000};
    case (op)
      lsu_pkg::LSU_LB:  result = {{(`LSU_XLEN-8){shifted[7]}}, shifted[7:0]};
      lsu_pkg::LSU_LH:  result = {{(`LSU_XLEN-16){shifted[15]}}, shifted[15:0]};
      lsu_pkg::LSU_LW:  result = {{(`LSU_XLEN-32){shifted[31]}}, shifted[31:0]};
      lsu_pkg::LSU_LBU: result = `LSU_XLEN'(shifted[7:0]);
      lsu_pkg::LSU_LHU: result = `LSU_XLEN'(shifted[15:0]);
      lsu_pkg::LSU_LWU: result = `LSU_XLEN'(shifted[31:0]);
      default:          result = shifted;
    endcase
    return result;
  endfunction

  assign stage_go    = stage_valid_i && !flush_i;
  assign stage_store = lsu_pkg::op_is_store(stage_i.op);
  assign covered     = (fwd_i.mask & stage_i.be) == stage_i.be;
  assign miss_start  = stage_go && !stage_store && !stage_i.misaligned && !covered;
  assign imm_wb      = stage_go && !miss_start;
  assign rsp_wb      = (state_q == LD_RSP) && mem_rsp_valid_i && !flush_i;
  assign wb_fire     = imm_wb || rsp_wb;

  // ========================================
  // Memory read FSM
  // ========================================

  always_comb begin
    state_d = state_q;
    case (state_q)
      LD_IDLE: begin
        if (miss_start) begin
          state_d = LD_REQ;
        end
      end
      LD_REQ: begin
        if (flush_i) begin
          state_d = mem_req_ready_i ? LD_DRAIN : LD_IDLE;
        end else if (mem_req_ready_i) begin
          state_d = LD_RSP;
        end
      end
      LD_RSP: begin
        if (mem_rsp_valid_i) begin
          state_d = flush_i ? LD_IDLE : LD_WB;
        end else if (flush_i) begin
          state_d = LD_DRAIN;
        end
      end
      // Owed response of a cancelled load is dropped
      LD_DRAIN: begin
        if (mem_rsp_valid_i) begin
          state_d = LD_IDLE;
        end
      end
      default: begin
        state_d = LD_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= LD_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (miss_start) begin
      pend_op_q   <= stage_i.op;
      pend_off_q  <= stage_i.offset;
      pend_rob_q  <= stage_i.rob_tag;
      pend_addr_q <= stage_i.word_addr;
      pend_fwd_q  <= fwd_i;
    end
  end

  assign ld_busy_o       = (state_q != LD_IDLE) || miss_start;
  assign mem_req_valid_o = state_q == LD_REQ;
  assign mem_req_addr_o  = pend_addr_q;

  // ========================================
  // Writeback
  // ========================================

  always_comb begin
    wb_d = '0;
    if (imm_wb) begin
      wb_d.rob_tag = stage_i.rob_tag;
      if (stage_i.misaligned) begin
        wb_d.exception = 1'b1;
        wb_d.cause     = stage_store ? `LSU_ECAUSE_W'(`LSU_ECAUSE_ST_MISALIGN)
                                     : `LSU_ECAUSE_W'(`LSU_ECAUSE_LD_MISALIGN);
      end else if (!stage_store) begin
        wb_d.data = load_value(stage_i.op, stage_i.offset, fwd_i, '0);
      end
    end else begin
      wb_d.rob_tag = pend_rob_q;
      wb_d.data    = load_value(pend_op_q, pend_off_q, pend_fwd_q, mem_rsp_data_i);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wb_valid_q <= 1'b0;
    end else begin
      wb_valid_q <= wb_fire;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wb_fire) begin
      wb_q <= wb_d;
    end
  end

  assign wb_valid_o = wb_valid_q;
  assign wb_o       = wb_q;

endmodule

`default_nettype wire

// ==== logic/lsu_store_queue.sv ====
// Circular queue of uncommitted stores that forwards bytes to loads and emits committed writes
`timescale 1ns/100ps
`default_nettype none

`include "lsu_macros.svh"

module lsu_store_queue (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                flush_i,
  input  logic                stage_valid_i,
  input  lsu_pkg::lsu_stage_t stage_i,
  input  logic                commit_i,
  output lsu_pkg::fwd_t       fwd_o,
  output logic                sq_full_o,
  output logic                st_valid_o,
  output lsu_pkg::st_write_t  st_o
);

  localparam int unsigned ptr_w = $clog2(`LSU_SQ_DEPTH);
  localparam int unsigned cnt_w = $clog2(`LSU_SQ_DEPTH + 1);

  lsu_pkg::sq_entry_t entries_q [`LSU_SQ_DEPTH];
  logic [ptr_w-1:0]   head_q;
  logic [ptr_w-1:0]   tail_q;
  logic [cnt_w-1:0]   count_q;
  logic               stage_is_store;
  logic               stage_store_ok;
  logic               stage_is_load;
  logic               push;
  logic               pop;
  logic               st_valid_q;
  lsu_pkg::st_write_t st_q;

  assign stage_is_store = stage_valid_i && lsu_pkg::op_is_store(stage_i.op);
  assign stage_store_ok = stage_is_store && !stage_i.misaligned;
  assign stage_is_load  = stage_valid_i && !lsu_pkg::op_is_store(stage_i.op) &&
                          !stage_i.misaligned;

  assign push = stage_store_ok && !flush_i;
  assign pop  = commit_i && (count_q != '0) && !flush_i;

  // Staged store already owns a slot
  assign sq_full_o = (count_q + cnt_w'(stage_store_ok)) >= cnt_w'(`LSU_SQ_DEPTH);

  // ========================================
  // Store-to-load forwarding
  // ========================================

  // Oldest to youngest so younger stores overwrite older bytes
  always_comb begin
    logic [ptr_w-1:0] idx;
    fwd_o = '0;
    idx   = '0;
    if (stage_is_load) begin
      for (int i = 0; i < `LSU_SQ_DEPTH; i++) begin
        idx = head_q + ptr_w'(i);
        if ((cnt_w'(i) < count_q) && (entries_q[idx].word_addr == stage_i.word_addr)) begin
          for (int b = 0; b < `LSU_BE_W; b++) begin
            if (entries_q[idx].be[b] && stage_i.be[b]) begin
              fwd_o.mask[b]          = 1'b1;
              fwd_o.data[8*b +: 8]   = entries_q[idx].data[8*b +: 8];
            end
          end
        end
      end
    end
  end

  // ========================================
  // Pointers and storage
  // ========================================

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else if (flush_i) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else begin
      if (push) begin
        tail_q <= tail_q + 1'b1;
      end
      if (pop) begin
        head_q <= head_q + 1'b1;
      end
      count_q <= count_q + cnt_w'(push) - cnt_w'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      entries_q[tail_q] <= '{word_addr: stage_i.word_addr, data: stage_i.data, be: stage_i.be};
    end
  end

  // Committed head leaves as a one-cycle write strobe
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      st_valid_q <= 1'b0;
    end else begin
      st_valid_q <= pop;
    end
  end

  always_ff @(posedge clk_i) begin
    if (pop) begin
      st_q <= '{word_addr: entries_q[head_q].word_addr,
                data:      entries_q[head_q].data,
                be:        entries_q[head_q].be};
    end
  end

  assign st_valid_o = st_valid_q;
  assign st_o       = st_q;

endmodule

`default_nettype wire

// ==== logic/lsu_agu.sv ====
// Address generation stage that turns each accepted request into the registered stage operation
`timescale 1ns/100ps
`default_nettype none

`include "lsu_macros.svh"

module lsu_agu (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                flush_i,
  input  logic                req_valid_i,
  output logic                req_ready_o,
  input  lsu_pkg::lsu_req_t   req_i,
  input  logic                sq_full_i,
  input  logic                ld_busy_i,
  output logic                stage_valid_o,
  output lsu_pkg::lsu_stage_t stage_o
);

  logic [`LSU_XLEN-1:0]  eff_addr;
  logic [`LSU_PLEN-1:0]  addr;
  logic [`LSU_OFF_W-1:0] offset;
  logic [1:0]            size;
  logic [`LSU_OFF_W:0]   num_bytes;
  logic [`LSU_OFF_W:0]   end_byte;
  logic                  misaligned;
  logic                  is_store;
  logic [`LSU_BE_W-1:0]  size_be;
  logic [`LSU_XLEN-1:0]  size_data;
  logic                  accept;
  lsu_pkg::lsu_stage_t   stage_d;
  logic                  stage_valid_q;
  lsu_pkg::lsu_stage_t   stage_q;

  // ========================================
  // Address decode
  // ========================================

  assign eff_addr = req_i.rs1 + req_i.imm;
  assign addr     = eff_addr[`LSU_PLEN-1:0];
  assign offset   = addr[`LSU_OFF_W-1:0];
  assign size     = lsu_pkg::op_size(req_i.op);
  assign is_store = lsu_pkg::op_is_store(req_i.op);

  assign num_bytes  = (`LSU_OFF_W+1)'(1) << size;
  assign end_byte   = {1'b0, offset} + num_bytes;
  // Access runs past the end of its 64-bit word
  assign misaligned = end_byte > (`LSU_OFF_W+1)'(`LSU_BE_W);

  // Low bytes of the access before placement in the word
  always_comb begin
    size_be   = '0;
    size_data = '0;
    for (int b = 0; b < `LSU_BE_W; b++) begin
      if (b < int'(num_bytes)) begin
        size_be[b]          = 1'b1;
        size_data[8*b +: 8] = req_i.rs2[8*b +: 8];
      end
    end
  end

  always_comb begin
    stage_d            = '0;
    stage_d.op         = req_i.op;
    stage_d.word_addr  = {addr[`LSU_PLEN-1:`LSU_OFF_W], {`LSU_OFF_W{1'b0}}};
    stage_d.offset     = offset;
    stage_d.rob_tag    = req_i.rob_tag;
    stage_d.misaligned = misaligned;
    if (!misaligned) begin
      stage_d.be = size_be << offset;
      if (is_store) begin
        stage_d.data = size_data << {offset, 3'b000};
      end
    end
  end

  // ========================================
  // Acceptance and stage register
  // ========================================

  // Stores also wait for a free queue slot
  assign req_ready_o = !flush_i && !ld_busy_i && !(is_store && sq_full_i);
  assign accept      = req_valid_i && req_ready_o;

  // Ready is low during flush, so the stage empties then
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      stage_valid_q <= 1'b0;
    end else begin
      stage_valid_q <= accept;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      stage_q <= stage_d;
    end
  end

  assign stage_valid_o = stage_valid_q;
  assign stage_o       = stage_q;

endmodule

`default_nettype wire

// ==== logic/lsu_pkg.sv ====
// Opcode enum, packed structs and op decoders shared by all load/store unit modules
`default_nettype none

`include "lsu_macros.svh"

package lsu_pkg;

  typedef enum logic [3:0] {
    LSU_LB,
    LSU_LH,
    LSU_LW,
    LSU_LD,
    LSU_LBU,
    LSU_LHU,
    LSU_LWU,
    LSU_SB,
    LSU_SH,
    LSU_SW,
    LSU_SD
  } lsu_op_e;

  typedef struct packed {
    lsu_op_e                op;
    logic [`LSU_XLEN-1:0]   rs1;
    logic [`LSU_XLEN-1:0]   rs2;
    logic [`LSU_XLEN-1:0]   imm;
    logic [`LSU_ROB_W-1:0]  rob_tag;
  } lsu_req_t;

  // Decoded operation held in the stage register
  typedef struct packed {
    lsu_op_e                op;
    logic [`LSU_PLEN-1:0]   word_addr;
    logic [`LSU_OFF_W-1:0]  offset;
    logic [`LSU_BE_W-1:0]   be;
    logic [`LSU_XLEN-1:0]   data;
    logic [`LSU_ROB_W-1:0]  rob_tag;
    logic                   misaligned;
  } lsu_stage_t;

  typedef struct packed {
    logic [`LSU_PLEN-1:0]   word_addr;
    logic [`LSU_XLEN-1:0]   data;
    logic [`LSU_BE_W-1:0]   be;
  } sq_entry_t;

  typedef struct packed {
    logic [`LSU_BE_W-1:0]   mask;
    logic [`LSU_XLEN-1:0]   data;
  } fwd_t;

  typedef struct packed {
    logic [`LSU_PLEN-1:0]   word_addr;
    logic [`LSU_XLEN-1:0]   data;
    logic [`LSU_BE_W-1:0]   be;
  } st_write_t;

  typedef struct packed {
    logic [`LSU_ROB_W-1:0]    rob_tag;
    logic [`LSU_XLEN-1:0]     data;
    logic                     exception;
    logic [`LSU_ECAUSE_W-1:0] cause;
  } lsu_wb_t;

  function automatic logic op_is_store(lsu_op_e op);
    return op inside {LSU_SB, LSU_SH, LSU_SW, LSU_SD};
  endfunction

  // Log2 of the access size in bytes
  function automatic logic [1:0] op_size(lsu_op_e op);
    logic [1:0] size;
    case (op)
      LSU_LB, LSU_LBU, LSU_SB: size = 2'd0;
      LSU_LH, LSU_LHU, LSU_SH: size = 2'd1;
      LSU_LW, LSU_LWU, LSU_SW: size = 2'd2;
      default:                 size = 2'd3;
    endcase
    return size;
  endfunction

endpackage

`default_nettype wire

// ==== include/lsu_macros.svh ====
// Widths, depths and exception codes of the load/store unit, included by package, RTL and testbench
`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

// ========================================
// Datapath widths
// ========================================

`define LSU_XLEN 64
`define LSU_PLEN 32

// Bytes per data word and bits of byte offset within it
`define LSU_BE_W 8
`define LSU_OFF_W 3

`define LSU_ROB_W 6

// ========================================
// Store queue
// ========================================

// Kept a power of two so the pointers wrap on their own
`define LSU_SQ_DEPTH 8

// ========================================
// Exception causes
// ========================================

`define LSU_ECAUSE_W 5
`define LSU_ECAUSE_LD_MISALIGN 4
`define LSU_ECAUSE_ST_MISALIGN 6

`endif
